// ==== reflet_pkg.sv ====
package reflet_pkg;

    // ====================
    // system bus
    // ====================

    localparam int bus_addr_w = 16;  // address width.
    localparam int bus_data_w = 8;   // data width.

    // ====================
    // address map
    // ====================

    localparam logic [bus_addr_w-1:0] timer0_base = 16'hFF10;  // three bytes.
    localparam logic [bus_addr_w-1:0] timer1_base = 16'hFF14;  // three bytes.
    localparam logic [bus_addr_w-1:0] irq_base    = 16'hFF18;  // two bytes.

    // ====================
    // register offsets
    // ====================

    // timer window
    localparam logic [1:0] off_pre1 = 2'd0;  // first prescaler.
    localparam logic [1:0] off_pre2 = 2'd1;  // second prescaler.
    localparam logic [1:0] off_mcnt = 2'd2;  // main count, zero stops the timer.

    // interrupt controller window
    localparam logic [1:0] off_irq_status = 2'd0;  // pending bits, write one to clear.
    localparam logic [1:0] off_irq_mask   = 2'd1;  // per source enable.

    localparam int n_timers = 2;  // interrupt sources.

endpackage

// ==== reflet_rw_register.sv ====
module reflet_rw_register
    import reflet_pkg::*;
#(
    parameter logic [1:0]            reg_addr      = 2'd0,
    parameter logic [bus_data_w-1:0] default_value = '0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic [1:0]            addr,
    input  logic                  write_en,
    input  logic [bus_data_w-1:0] data_in,
    output logic [bus_data_w-1:0] data_out,
    output logic [bus_data_w-1:0] data
);

    logic hit;

    // the window decode is done by the parent, only the offset is checked here
    assign hit = enable && (addr == reg_addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data <= default_value;
        end else if (hit && write_en) begin
            data <= data_in;  // load on a bus write.
        end
    end

    // zero when not selected so the parent can OR the read data.
    assign data_out = hit ? data : '0;

endmodule

// ==== reflet_counter.sv ====
module reflet_counter #(
    parameter int size = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            clear,
    input  logic            enable,
    input  logic [size-1:0] max,
    output logic            out
);

    logic [size-1:0] count;
    logic            at_top;

    // last state before the wrap.
    assign at_top = (count == max - 1'b1);

    // terminal pulse, one cycle per wrap.
    assign out = enable && !clear && at_top;

    // ====================
    // count register
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;  // held while stopped.
        end else if (enable) begin
            if (at_top) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// ==== reflet_timer.sv ====
module reflet_timer
    import reflet_pkg::*;
#(
    parameter logic [bus_addr_w-1:0] base_addr = timer0_base
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic [bus_addr_w-1:0] addr,
    input  logic                  write_en,
    input  logic [bus_data_w-1:0] data_in,
    output logic [bus_data_w-1:0] data_out,
    output logic                  interrupt
);

    // ====================
    // address decode
    // ====================

    logic                  using_timer;
    logic [bus_addr_w-1:0] addr_rel;
    logic [1:0]            offset;

    assign using_timer = enable && (addr >= base_addr) && (addr < base_addr + 3);
    assign addr_rel    = addr - base_addr;
    assign offset      = addr_rel[1:0];  // byte inside the window.

    // ====================
    // configuration registers
    // ====================

    logic [bus_data_w-1:0] dout_pre1, dout_pre2, dout_mcnt;
    logic [bus_data_w-1:0] pre1, pre2, mcnt;

    reflet_rw_register #(.reg_addr(off_pre1), .default_value('0)) reg_pre1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (using_timer),
        .addr     (offset),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (dout_pre1),
        .data     (pre1)
    );

    reflet_rw_register #(.reg_addr(off_pre2), .default_value('0)) reg_pre2 (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (using_timer),
        .addr     (offset),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (dout_pre2),
        .data     (pre2)
    );

    reflet_rw_register #(.reg_addr(off_mcnt), .default_value('0)) reg_mcnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (using_timer),
        .addr     (offset),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (dout_mcnt),
        .data     (mcnt)
    );

    assign data_out = dout_pre1 | dout_pre2 | dout_mcnt;

    // ====================
    // counter chain
    // ====================

    logic                  timer_stop;
    logic [bus_data_w:0]   pre1_max, pre2_max;  // one bit wider for the +1.
    logic                  pre1_out, pre2_out;

    assign timer_stop = (mcnt == '0);  // zero main count stops the timer.
    assign pre1_max   = {1'b0, pre1} + 1'b1;
    assign pre2_max   = {1'b0, pre2} + 1'b1;

    reflet_counter #(.size(bus_data_w + 1)) pre1_cnt (
        .clk(clk), .rst_n(rst_n), .clear(timer_stop),
        .enable(1'b1), .max(pre1_max), .out(pre1_out)
    );

    reflet_counter #(.size(bus_data_w + 1)) pre2_cnt (
        .clk(clk), .rst_n(rst_n), .clear(timer_stop),
        .enable(pre1_out), .max(pre2_max), .out(pre2_out)
    );

    // its wrap pulse is the interrupt.
    reflet_counter #(.size(bus_data_w)) mcnt_cnt (
        .clk(clk), .rst_n(rst_n), .clear(timer_stop),
        .enable(pre2_out), .max(mcnt), .out(interrupt)
    );

endmodule

// ==== reflet_irq_ctrl.sv ====
module reflet_irq_ctrl
    import reflet_pkg::*;
#(
    parameter logic [bus_addr_w-1:0] base_addr = irq_base
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic [bus_addr_w-1:0] addr,
    input  logic                  write_en,
    input  logic [bus_data_w-1:0] data_in,
    output logic [bus_data_w-1:0] data_out,
    input  logic [n_timers-1:0]   timer_irq,
    output logic                  irq
);

    // ====================
    // address decode
    // ====================

    logic                  using_irq;
    logic [bus_addr_w-1:0] addr_rel;
    logic [1:0]            offset;
    logic                  status_sel;

    assign using_irq  = enable && (addr >= base_addr) && (addr < base_addr + 2);
    assign addr_rel   = addr - base_addr;
    assign offset     = addr_rel[1:0];
    assign status_sel = using_irq && (offset == off_irq_status);

    // ====================
    // mask register
    // ====================

    logic [bus_data_w-1:0] dout_mask;
    logic [bus_data_w-1:0] mask;

    reflet_rw_register #(.reg_addr(off_irq_mask), .default_value('0)) reg_mask (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (using_irq),
        .addr     (offset),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (dout_mask),
        .data     (mask)
    );

    // ====================
    // pending bits
    // ====================

    logic [n_timers-1:0]   pending;
    logic [n_timers-1:0]   clear_bits;
    logic [bus_data_w-1:0] dout_status;

    // write one to clear.
    assign clear_bits = (status_sel && write_en) ? data_in[n_timers-1:0] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clear_bits) | timer_irq;  // a new pulse wins.
        end
    end

    assign dout_status = status_sel ? {{(bus_data_w - n_timers){1'b0}}, pending} : '0;
    assign data_out    = dout_status | dout_mask;

    // level output, high while any unmasked source is pending.
    assign irq = |(pending & mask[n_timers-1:0]);

endmodule

// ==== reflet_timer_subsys.sv ====
module reflet_timer_subsys
    import reflet_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic [bus_addr_w-1:0] addr,
    input  logic                  write_en,
    input  logic [bus_data_w-1:0] data_in,
    output logic [bus_data_w-1:0] data_out,
    output logic                  irq
);

    logic [bus_data_w-1:0] dout_timer0;
    logic [bus_data_w-1:0] dout_timer1;
    logic [bus_data_w-1:0] dout_irq;
    logic [n_timers-1:0]   timer_irq;  // one pulse line per timer.

    // ====================
    // timers
    // ====================

    reflet_timer #(.base_addr(timer0_base)) i_timer0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .addr      (addr),
        .write_en  (write_en),
        .data_in   (data_in),
        .data_out  (dout_timer0),
        .interrupt (timer_irq[0])
    );

    reflet_timer #(.base_addr(timer1_base)) i_timer1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .addr      (addr),
        .write_en  (write_en),
        .data_in   (data_in),
        .data_out  (dout_timer1),
        .interrupt (timer_irq[1])
    );

    // ====================
    // interrupt controller
    // ====================

    reflet_irq_ctrl #(.base_addr(irq_base)) i_irq_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .addr      (addr),
        .write_en  (write_en),
        .data_in   (data_in),
        .data_out  (dout_irq),
        .timer_irq (timer_irq),
        .irq       (irq)
    );

    // each block returns zero outside its own window.
    assign data_out = dout_timer0 | dout_timer1 | dout_irq;

endmodule

// ==== reflet_timer_subsys_sva.sv ====
module reflet_timer_subsys_sva
    import reflet_pkg::*;
(
    input logic                  clk,
    input logic                  rst_n,
    input logic                  enable,
    input logic [bus_addr_w-1:0] addr,
    input logic [bus_data_w-1:0] data_out,
    input logic [n_timers-1:0]   timer_irq,
    input logic                  irq
);

    timeunit 1ns;
    timeprecision 100ps;

    logic in_map;
    logic pulse_seen;

    assign in_map = ((addr >= timer0_base) && (addr < timer0_base + 3))
                 || ((addr >= timer1_base) && (addr < timer1_base + 3))
                 || ((addr >= irq_base) && (addr < irq_base + 2));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pulse_seen <= 1'b0;
        end else if (|timer_irq) begin
            pulse_seen <= 1'b1;  // any timer has fired since reset.
        end
    end

    for (genvar i = 0; i < n_timers; i++) begin : g_pulse
        single_cycle_pulse: assert property (@(posedge clk) disable iff (!rst_n)
            timer_irq[i] |=> !timer_irq[i])
            else $error("interrupt pulse of timer %0d longer than one cycle", i);
    end

    irq_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !pulse_seen |-> !irq)
        else $error("irq high before any timer pulse");

    unmapped_read_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (!enable || !in_map) |-> (data_out == '0))
        else $error("data_out not zero outside the address map");

endmodule

bind reflet_timer_subsys reflet_timer_subsys_sva i_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .enable    (enable),
    .addr      (addr),
    .data_out  (data_out),
    .timer_irq (timer_irq),
    .irq       (irq)
);

// ==== tb_reflet_timer_subsys.sv ====
module tb_reflet_timer_subsys
    import reflet_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period = 100;
    localparam int wait_limit = 4000;  // cycles, well above the longest period tried.

    // registers that read back what was written.
    localparam logic [bus_addr_w-1:0] rw_addrs [7] = '{
        timer0_base + off_pre1, timer0_base + off_pre2, timer0_base + off_mcnt,
        timer1_base + off_pre1, timer1_base + off_pre2, timer1_base + off_mcnt,
        irq_base + off_irq_mask
    };

    // holes and neighbours of the map.
    localparam logic [bus_addr_w-1:0] unmapped_addrs [6] = '{
        16'hFF0F, 16'hFF13, 16'hFF17, 16'hFF1A, 16'hFF1F, 16'h0000
    };

    logic                  clk;
    logic                  rst_n;
    logic                  enable;
    logic [bus_addr_w-1:0] addr;
    logic                  write_en;
    logic [bus_data_w-1:0] data_in;
    logic [bus_data_w-1:0] data_out;
    logic                  irq;

    int unsigned           cycles = 0;     // rising edges since time zero.
    logic [bus_data_w-1:0] reg_model [16];  // indexed by addr[3:0].

    reflet_timer_subsys i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .addr     (addr),
        .write_en (write_en),
        .data_in  (data_in),
        .data_out (data_out),
        .irq      (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // ====================
    // reference and checks
    // ====================

    function automatic int timer_period(input logic [7:0] pre1, pre2, mcnt);
        return (int'(pre1) + 1) * (int'(pre2) + 1) * int'(mcnt);
    endfunction

    function automatic logic [bus_addr_w-1:0] timer_base(input int idx);
        return (idx == 0) ? timer0_base : timer1_base;
    endfunction

    task automatic end_with_failure();
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: no %s within %0d cycles at %0t ns", what, wait_limit, $time);
        end_with_failure();
    endtask

    task automatic check_byte(input logic [bus_data_w-1:0] got, exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s gave 0x%02h, expected 0x%02h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_period(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Fail at %0t ns: %s was %0d cycles, expected %0d", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_bit(input logic got, exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    // ====================
    // bus tasks
    // ====================

    task automatic bus_write(input logic [bus_addr_w-1:0] a, input logic [bus_data_w-1:0] d);
        @(negedge clk);
        enable   = 1'b1;
        write_en = 1'b1;
        addr     = a;
        data_in  = d;
        @(negedge clk);  // written at the rising edge in between.
        enable   = 1'b0;
        write_en = 1'b0;
    endtask

    task automatic bus_read(input logic [bus_addr_w-1:0] a, output logic [bus_data_w-1:0] d);
        @(negedge clk);
        enable   = 1'b1;
        write_en = 1'b0;
        addr     = a;
        #(clk_period / 4);
        d        = data_out;  // combinational read, settled well before the edge.
        @(negedge clk);
        enable   = 1'b0;
    endtask

    task automatic write_reg(input logic [bus_addr_w-1:0] a, input logic [bus_data_w-1:0] d);
        bus_write(a, d);
        reg_model[a[3:0]] = d;
    endtask

    task automatic configure_timer(input int idx, input logic [7:0] pre1, pre2, mcnt);
        write_reg(timer_base(idx) + off_mcnt, 8'h00);  // stop before touching the prescalers.
        write_reg(timer_base(idx) + off_pre1, pre1);
        write_reg(timer_base(idx) + off_pre2, pre2);
        write_reg(timer_base(idx) + off_mcnt, mcnt);
    endtask

    task automatic clear_status(input logic [bus_data_w-1:0] bits);
        bus_write(irq_base + off_irq_status, bits);
    endtask

    task automatic wait_irq_high(input string what, output int unsigned at_cycle);
        int n;
        n = 0;
        @(negedge clk);
        while (irq !== 1'b1) begin
            if (n == wait_limit) begin
                report_timeout(what);
            end
            n++;
            @(negedge clk);
        end
        at_cycle = cycles;
    endtask

    // the first rise only syncs up, the intervals after it are compared.
    task automatic check_intervals(input int idx, input int exp, input int count,
                                   input string what);
        int unsigned t_prev;
        int unsigned t_now;
        clear_status(8'(1 << idx));
        wait_irq_high(what, t_prev);
        clear_status(8'(1 << idx));
        check_bit(irq, 1'b0, "irq after status clear");
        wait_irq_high(what, t_prev);
        clear_status(8'(1 << idx));
        for (int k = 0; k < count; k++) begin
            wait_irq_high(what, t_now);
            check_period(int'(t_now - t_prev), exp, what);
            clear_status(8'(1 << idx));
            check_bit(irq, 1'b0, "irq after status clear");
            t_prev = t_now;
        end
    endtask

    // ====================
    // test sequence
    // ====================

    initial begin
        logic [bus_data_w-1:0] rd;
        logic [7:0]            p1, p2, mc;
        int                    idx;
        int                    last_period;
        int                    n;
        int unsigned           t;

        void'($urandom(20941));
        rst_n    = 1'b0;
        enable   = 1'b0;
        addr     = '0;
        write_en = 1'b0;
        data_in  = '0;
        foreach (reg_model[i]) reg_model[i] = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // registers
        check_bit(irq, 1'b0, "irq after reset");
        bus_read(irq_base + off_irq_status, rd);
        check_byte(rd, 8'h00, "status after reset");
        foreach (rw_addrs[i]) begin
            bus_read(rw_addrs[i], rd);
            check_byte(rd, 8'h00, $sformatf("reset value at 0x%04h", rw_addrs[i]));
        end
        foreach (rw_addrs[i]) begin
            rd = 8'($urandom);
            if (rw_addrs[i][1:0] == off_pre1) begin
                rd[0] = 1'b1;  // pre1 of either timer, keeps pulses apart.
            end
            write_reg(rw_addrs[i], rd);
        end
        foreach (rw_addrs[i]) begin
            bus_read(rw_addrs[i], rd);
            check_byte(rd, reg_model[rw_addrs[i][3:0]], $sformatf("read of 0x%04h", rw_addrs[i]));
        end
        foreach (unmapped_addrs[i]) begin
            bus_read(unmapped_addrs[i], rd);
            check_byte(rd, 8'h00, $sformatf("unmapped read of 0x%04h", unmapped_addrs[i]));
        end

        // period, both timers in turn
        last_period = 0;
        idx = 0;
        for (int k = 0; k < 4; k++) begin
            idx = k % 2;
            write_reg(timer0_base + off_mcnt, 8'h00);
            write_reg(timer1_base + off_mcnt, 8'h00);
            write_reg(irq_base + off_irq_mask, 8'(1 << idx));
            p1 = 8'(1 + $urandom % 7);
            p2 = 8'($urandom % 8);
            mc = 8'(2 + $urandom % 14);
            last_period = timer_period(p1, p2, mc);
            configure_timer(idx, p1, p2, mc);
            check_intervals(idx, last_period, 2, $sformatf("timer %0d period", idx));
        end

        // stop, mask still set for the last timer
        write_reg(timer_base(idx) + off_mcnt, 8'h00);
        clear_status(8'h03);
        n = 0;
        while (n < last_period + 16) begin
            @(negedge clk);
            check_bit(irq, 1'b0, "irq while stopped");
            n++;
        end
        bus_read(irq_base + off_irq_status, rd);
        check_byte(rd, 8'h00, "status while stopped");

        // mask
        write_reg(irq_base + off_irq_mask, 8'h00);
        configure_timer(0, 8'd1, 8'd0, 8'd4);
        n  = 0;
        rd = '0;
        while (rd[0] !== 1'b1) begin
            if (n == wait_limit) begin
                report_timeout("pending bit of timer 0");
            end
            n++;
            bus_read(irq_base + off_irq_status, rd);
        end
        write_reg(timer0_base + off_mcnt, 8'h00);
        check_bit(irq, 1'b0, "irq with mask cleared");
        bus_read(irq_base + off_irq_status, rd);
        check_byte(rd, 8'h01, "status with mask cleared");
        write_reg(irq_base + off_irq_mask, 8'h01);
        check_bit(irq, 1'b1, "irq after mask set");
        clear_status(8'h01);
        check_bit(irq, 1'b0, "irq after status clear");
        bus_read(irq_base + off_irq_status, rd);
        check_byte(rd, 8'h00, "status after clear");

        // independence
        configure_timer(0, 8'd3, 8'd1, 8'd5);
        wait_irq_high("timer 0 interrupt", t);
        bus_read(irq_base + off_irq_status, rd);
        check_byte(rd, 8'h01, "status with timer 0 alone");
        write_reg(timer0_base + off_mcnt, 8'h00);
        clear_status(8'h03);
        write_reg(irq_base + off_irq_mask, 8'h02);
        configure_timer(1, 8'd2, 8'd2, 8'd7);
        wait_irq_high("timer 1 interrupt", t);
        bus_read(irq_base + off_irq_status, rd);
        check_byte(rd, 8'h02, "status with timer 1 alone");
        configure_timer(0, 8'd3, 8'd1, 8'd5);
        check_intervals(1, timer_period(8'd2, 8'd2, 8'd7), 2, "timer 1 period beside timer 0");
        write_reg(irq_base + off_irq_mask, 8'h01);
        check_intervals(0, timer_period(8'd3, 8'd1, 8'd5), 2, "timer 0 period beside timer 1");

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== vlog.f ====
reflet_pkg.sv
reflet_rw_register.sv
reflet_counter.sv
reflet_timer.sv
reflet_irq_ctrl.sv
reflet_timer_subsys.sv
reflet_timer_subsys_sva.sv
tb_reflet_timer_subsys.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the timer subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

top=tb_reflet_timer_subsys
log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module "$top" -f vlog.f -o sim_bin

status=0
./obj_dir/sim_bin > "$log" 2>&1 || status=$?
cat "$log"

if grep -q "Simulation failed" "$log" || [ "$status" -ne 0 ]; then
    echo "run.sh: simulation reported a failure"
    exit 1
fi
echo "run.sh: simulation passed"
